// File: Makefile
TOP := rv_ex_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f all.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

lint:
	verilator --lint-only -Wall --timescale 1ns/1ps --top-module rv_ex_top \
		rv_pkg.sv rv_decode.sv rv_execute.sv rv_ex_top.sv

clean:
	rm -rf obj_dir $(LOG)

// File: all.f
rv_pkg.sv
rv_decode.sv
rv_execute.sv
rv_ex_top.sv
rv_ex_props.sv
rv_ex_tb.sv

// File: rv_decode.sv
`default_nettype none

module rv_decode
(
    input  wire                             i_valid,
    input  wire [rv_pkg::XLEN-1:0]          i_instr,
    input  wire [rv_pkg::IADDR_BITS-1:0]    i_pc,
    input  wire [rv_pkg::XLEN-1:0]          i_rs1_data,
    input  wire [rv_pkg::XLEN-1:0]          i_rs2_data,
    input  wire                             i_branch_pred,
    input  wire [rv_pkg::XLEN-1:0]          i_csr_data,
    output rv_pkg::ex_in_t                  o_bundle
);

    logic [6:0]                     opcode;
    logic [rv_pkg::F3_BITS-1:0]     funct3;
    logic                           funct7_alt;
    logic [rv_pkg::REG_BITS-1:0]    rd;
    logic [rv_pkg::XLEN-1:0]        imm_i;
    logic [rv_pkg::XLEN-1:0]        imm_s;
    logic [rv_pkg::XLEN-1:0]        imm_b;
    logic [rv_pkg::XLEN-1:0]        imm_u;
    logic [rv_pkg::XLEN-1:0]        imm_j;
    logic                           sub_en;
    rv_pkg::alu_res_t               op_res;
    rv_pkg::alu_ctrl_t              op_ctrl;
    rv_pkg::alu_ctrl_t              br_ctrl;
    rv_pkg::ex_in_t                 b;

    assign opcode     = i_instr[6:0];
    assign funct3     = i_instr[14:12];
    assign funct7_alt = i_instr[30];
    assign rd         = i_instr[11:7];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    assign sub_en = (opcode == rv_pkg::OPC_OP) & funct7_alt;  // ADDI has no SUB form.

    // ALU selection shared by OP and OP-IMM.
    always_comb
    begin
        op_res  = '0;
        op_ctrl = '0;
        case (funct3)
        3'b000:
        begin
            op_res.arith      = 1'b1;
            op_ctrl.arith_sub = sub_en;
            op_ctrl.arith_add = !sub_en;
        end
        3'b001:
        begin
            op_res.shift      = 1'b1;
            op_ctrl.arith_shl = 1'b1;
        end
        3'b010:
        begin
            op_res.cmp      = 1'b1;
            op_ctrl.cmp_lts = 1'b1;
        end
        3'b011:
        begin
            op_res.cmp      = 1'b1;
            op_ctrl.cmp_ltu = 1'b1;
        end
        3'b100:
        begin
            op_res.bits      = 1'b1;
            op_ctrl.bits_xor = 1'b1;
        end
        3'b101:
        begin
            op_res.shift               = 1'b1;
            op_ctrl.arith_shr          = 1'b1;
            op_ctrl.shift_arithmetical = funct7_alt;
        end
        3'b110:
        begin
            op_res.bits     = 1'b1;
            op_ctrl.bits_or = 1'b1;
        end
        default:
        begin
            op_res.bits      = 1'b1;
            op_ctrl.bits_and = 1'b1;
        end
        endcase
    end

    // Odd funct3 values are the negated compares (BNE, BGE, BGEU).
    always_comb
    begin
        br_ctrl              = '0;
        br_ctrl.cmp_inversed = funct3[0];
        case (funct3[2:1])
        2'b10:   br_ctrl.cmp_lts = 1'b1;
        2'b11:   br_ctrl.cmp_ltu = 1'b1;
        default: br_ctrl.cmp_eq  = 1'b1;
        endcase
    end

    always_comb
    begin
        b                  = '0;
        b.op1              = i_rs1_data;
        b.op2              = imm_i;
        b.reg_data2        = i_rs2_data;
        b.res.arith        = 1'b1;
        b.ctrl.arith_add   = 1'b1;
        b.rd               = rd;
        b.funct3           = funct3;
        b.branch_pred      = i_branch_pred;
        b.pc_next          = i_pc + rv_pkg::IADDR_BITS'(4);
        b.pc_target_base   = i_pc;
        b.pc_target_offset = rv_pkg::IADDR_BITS'(imm_i);

        case (opcode)
        rv_pkg::OPC_OP:
        begin
            b.op2         = i_rs2_data;
            b.res         = op_res;
            b.ctrl        = op_ctrl;
            b.reg_write   = 1'b1;
            b.res_src.alu = 1'b1;
        end
        rv_pkg::OPC_OP_IMM:
        begin
            b.res         = op_res;
            b.ctrl        = op_ctrl;
            b.reg_write   = 1'b1;
            b.res_src.alu = 1'b1;
        end
        rv_pkg::OPC_LUI:
        begin
            b.op1         = '0;
            b.op2         = imm_u;
            b.reg_write   = 1'b1;
            b.res_src.alu = 1'b1;
        end
        rv_pkg::OPC_AUIPC:
        begin
            b.op1         = rv_pkg::XLEN'(i_pc);
            b.op2         = imm_u;
            b.reg_write   = 1'b1;
            b.res_src.alu = 1'b1;
        end
        rv_pkg::OPC_JAL, rv_pkg::OPC_JALR:
        begin
            b.op1             = rv_pkg::XLEN'(i_pc);
            b.op2             = rv_pkg::XLEN'(4);   // Link address.
            b.reg_write       = 1'b1;
            b.res_src.pc_next = 1'b1;
            b.inst_jal_jalr   = 1'b1;
            if (opcode == rv_pkg::OPC_JAL)
            begin
                b.pc_target_offset = rv_pkg::IADDR_BITS'(imm_j);
            end
            else
            begin
                b.pc_target_base = rv_pkg::IADDR_BITS'(i_rs1_data);
            end
        end
        rv_pkg::OPC_BRANCH:
        begin
            b.op2              = i_rs2_data;
            b.res              = '0;
            b.res.cmp          = 1'b1;
            b.ctrl             = br_ctrl;
            b.inst_branch      = 1'b1;
            b.pc_target_offset = rv_pkg::IADDR_BITS'(imm_b);
        end
        rv_pkg::OPC_LOAD:
        begin
            b.reg_write   = 1'b1;
            b.res_src.mem = 1'b1;
        end
        rv_pkg::OPC_STORE:
        begin
            b.op2   = imm_s;
            b.store = 1'b1;
        end
        rv_pkg::OPC_SYSTEM:
        begin
            if (funct3 != 3'b000)
            begin
                b.csr_read    = 1'b1;
                b.reg_data2   = i_csr_data;     // A CSR read has no store data to carry.
                b.reg_write   = 1'b1;
                b.res_src.alu = 1'b1;
            end
            else
            begin
                b.to_trap = 1'b1;               // ECALL or EBREAK.
            end
        end
        default: b.to_trap = 1'b1;
        endcase

        if (!i_valid)
        begin
            b.store         = 1'b0;
            b.reg_write     = 1'b0;
            b.inst_jal_jalr = 1'b0;
            b.inst_branch   = 1'b0;
            b.branch_pred   = 1'b0;
            b.csr_read      = 1'b0;
            b.to_trap       = 1'b0;
            b.rd            = '0;
            b.res_src       = '0;
        end
    end

    assign o_bundle = b;

endmodule

`default_nettype wire

// File: rv_ex_props.sv
`default_nettype none

module rv_ex_props
(
    input wire                  i_clk,
    input wire                  i_rst_n,
    input wire                  i_flush,
    input wire rv_pkg::ex_out_t i_ex
);

    timeunit 1ns;
    timeprecision 1ps;

    // A store always enables the byte lane its address points at, so wsel is never zero.
    store_has_lanes: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_ex.store |-> i_ex.wsel[i_ex.add[1:0]])
        else $error("store issued without the addressed byte lane selected");

    // A flushed slot is a bubble and can never redirect fetch.
    flush_blocks_redirect: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_flush |=> !i_ex.pc_select)
        else $error("redirect raised in the cycle after a flush");

    trap_has_no_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_ex.to_trap |-> !(i_ex.store | i_ex.reg_write))
        else $error("trapping instruction also writes a register or memory");

    one_result_source: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0({i_ex.res_src.pc_next, i_ex.res_src.mem, i_ex.res_src.alu}))
        else $error("more than one write-back source selected");

endmodule

bind rv_execute rv_ex_props props_i
(
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_flush (i_flush),
    .i_ex    (o_ex)
);

`default_nettype wire

// File: rv_ex_tb.sv
`default_nettype none

module rv_ex_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_TXN      = 4000;
    localparam int CLK_PERIOD = 4;

    typedef struct packed {
        logic        live;                  // Valid and not flushed.
        logic        chk_result;
        logic        chk_add;
        logic        chk_target;
        logic        chk_lanes;
        logic        chk_rd;
        logic        chk_funct3;
        logic        pc_select;
        logic        store;
        logic        reg_write;
        logic        to_trap;
        logic [4:0]  rd;
        logic [2:0]  res_src;               // Same bit order as res_src_t.
        logic [2:0]  funct3;
        logic [31:0] result;
        logic [31:0] add;
        logic [31:0] target;
        logic [31:0] wdata;
        logic [3:0]  wsel;
    } expect_t;

    logic            clk;
    logic            rst_n;
    logic            valid;
    logic [31:0]     instr;
    logic [31:0]     pc;
    logic [31:0]     rs1_data;
    logic [31:0]     rs2_data;
    logic            branch_pred;
    logic [31:0]     csr_data;
    logic            flush;
    rv_pkg::ex_out_t ex;

    logic [31:0]     seed;
    int              fail_count;
    logic            run_passed;
    logic            fail_reported;
    expect_t         pending;

    rv_ex_top dut_i
    (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_valid       (valid),
        .i_instr       (instr),
        .i_pc          (pc),
        .i_rs1_data    (rs1_data),
        .i_rs2_data    (rs2_data),
        .i_branch_pred (branch_pred),
        .i_csr_data    (csr_data),
        .i_flush       (flush),
        .o_ex          (ex)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int pick(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'({9'b0, r[30:8]}) % n;
    endfunction

    task automatic abort_run();
        fail_reported = 1'b1;
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want)
        else
        begin
            fail_count++;
            $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, want);
            abort_run();
        end
    endtask

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic sub,
                                              input logic sra, input logic [31:0] a,
                                              input logic [31:0] b);
        case (f3)
        3'd0:    return sub ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'b0, $signed(a) < $signed(b)};
        3'd3:    return {31'b0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return sra ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
        endcase
    endfunction

    // Random fields first, then the opcode group patches what the ISA fixes.
    function automatic logic [31:0] make_instr();
        logic [31:0] r;
        logic [31:0] sel;
        logic [6:0]  opc;
        r   = next_rand();
        sel = next_rand();
        if (pick(100) < 3)
        begin
            opc = r[6:0];
            while (opc inside {rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM, rv_pkg::OPC_LUI,
                               rv_pkg::OPC_AUIPC, rv_pkg::OPC_JAL, rv_pkg::OPC_JALR,
                               rv_pkg::OPC_BRANCH, rv_pkg::OPC_LOAD, rv_pkg::OPC_STORE,
                               rv_pkg::OPC_SYSTEM})
            begin
                opc = opc + 7'd1;
            end
            return {r[31:7], opc};
        end
        case (pick(10))
        0:
        begin
            opc      = rv_pkg::OPC_OP;
            r[31:25] = {1'b0, sel[20] && (r[13:12] == 2'b00 || r[14:12] == 3'd5), 5'b0};
        end
        1:
        begin
            opc = rv_pkg::OPC_OP_IMM;
            if (r[13:12] == 2'b01)
            begin
                r[31:25] = {1'b0, sel[20] && r[14], 5'b0};  // SLLI, SRLI or SRAI.
            end
        end
        2: opc = rv_pkg::OPC_LUI;
        3: opc = rv_pkg::OPC_AUIPC;
        4: opc = rv_pkg::OPC_JAL;
        5:
        begin
            opc       = rv_pkg::OPC_JALR;
            r[14:12]  = 3'd0;
        end
        6:
        begin
            opc = rv_pkg::OPC_BRANCH;
            if (r[14:13] == 2'b01)
            begin
                r[14] = 1'b1;
            end
        end
        7:
        begin
            opc = rv_pkg::OPC_LOAD;
            if (r[14:12] == 3'd3 || r[14:13] == 2'b11)
            begin
                r[14:12] = 3'd2;
            end
        end
        8:
        begin
            opc      = rv_pkg::OPC_STORE;
            r[14]    = 1'b0;
            if (r[13:12] == 2'b11)
            begin
                r[13] = 1'b0;
            end
        end
        default:
        begin
            opc = rv_pkg::OPC_SYSTEM;
            if (sel[20])
            begin
                r[31:7] = {11'b0, r[20], 13'b0};    // ECALL or EBREAK.
            end
            else if (r[14:12] == 3'd0)
            begin
                r[12] = 1'b1;
            end
        end
        endcase
        return {r[31:7], opc};
    endfunction

    function automatic expect_t predict();
        expect_t     e;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic        jump;
        logic        taken;
        e      = '0;
        e.live = valid && !flush;
        if (!e.live)
        begin
            e.chk_rd = 1'b1;
            return e;
        end
        opc   = instr[6:0];
        f3    = instr[14:12];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_u = {instr[31:12], 12'b0};
        imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        jump  = 1'b0;
        taken = 1'b0;
        e.rd     = instr[11:7];
        e.funct3 = f3;
        case (opc)
        rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM:
        begin
            e.result = alu_model(f3, opc == rv_pkg::OPC_OP && instr[30], instr[30], rs1_data,
                                 (opc == rv_pkg::OPC_OP) ? rs2_data : imm_i);
            e.res_src = 3'b001;
        end
        rv_pkg::OPC_LUI:   e.result = imm_u;
        rv_pkg::OPC_AUIPC: e.result = pc + imm_u;
        rv_pkg::OPC_JAL, rv_pkg::OPC_JALR:
        begin
            jump     = 1'b1;
            e.result = pc + 32'd4;
            e.target = (opc == rv_pkg::OPC_JAL) ? pc + imm_j : rs1_data + imm_i;
            e.res_src = 3'b100;
            e.chk_target = 1'b1;
        end
        rv_pkg::OPC_BRANCH:
        begin
            case (f3)
            3'd0:    taken = rs1_data == rs2_data;
            3'd1:    taken = rs1_data != rs2_data;
            3'd4:    taken = $signed(rs1_data) < $signed(rs2_data);
            3'd5:    taken = $signed(rs1_data) >= $signed(rs2_data);
            3'd6:    taken = rs1_data < rs2_data;
            default: taken = rs1_data >= rs2_data;
            endcase
            e.target     = pc + imm_b;
            e.chk_target = 1'b1;
        end
        rv_pkg::OPC_LOAD:
        begin
            e.add        = rs1_data + imm_i;
            e.res_src    = 3'b010;
            e.chk_add    = 1'b1;
            e.chk_funct3 = 1'b1;
        end
        rv_pkg::OPC_STORE:
        begin
            e.store      = 1'b1;
            e.add        = rs1_data + imm_s;
            e.chk_add    = 1'b1;
            e.chk_lanes  = 1'b1;
            e.chk_funct3 = 1'b1;
            case (f3)
            3'd0:
            begin
                e.wdata = {4{rs2_data[7:0]}};
                e.wsel  = 4'b0001 << e.add[1:0];
            end
            3'd1:
            begin
                e.wdata = {2{rs2_data[15:0]}};
                e.wsel  = e.add[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                e.wdata = rs2_data;
                e.wsel  = 4'b1111;
            end
            endcase
        end
        rv_pkg::OPC_SYSTEM:
        begin
            if (f3 == 3'd0)
            begin
                e.to_trap = 1'b1;
            end
            else
            begin
                e.result  = csr_data;
                e.res_src = 3'b001;
            end
        end
        default: e.to_trap = 1'b1;
        endcase
        if (opc inside {rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC})
        begin
            e.res_src = 3'b001;
        end
        e.reg_write  = e.res_src != 3'b000;
        e.chk_rd     = e.reg_write;
        e.chk_result = e.reg_write && !e.res_src[1];
        e.pc_select  = (jump | taken) ^ branch_pred;
        if (branch_pred)
        begin
            e.target     = pc + 32'd4;  // Fetch already left; a miss goes back to pc_next.
            e.chk_target = 1'b1;
        end
        return e;
    endfunction

    task automatic check_outputs(input expect_t e);
        logic [2:0] src;
        src = ex.res_src;
        check_field("pc_select", 32'(ex.pc_select), 32'(e.pc_select));
        check_field("store", 32'(ex.store), 32'(e.store));
        check_field("reg_write", 32'(ex.reg_write), 32'(e.reg_write));
        check_field("to_trap", 32'(ex.to_trap), 32'(e.to_trap));
        check_field("res_src", 32'(src), 32'(e.res_src));
        if (e.chk_rd)
            check_field("rd", 32'(ex.rd), 32'(e.rd));
        if (e.chk_funct3)
            check_field("funct3", 32'(ex.funct3), 32'(e.funct3));
        if (e.chk_result)
            check_field("result", ex.result, e.result);
        if (e.chk_add)
            check_field("add", ex.add, e.add);
        if (e.chk_target)
            check_field("pc_target", ex.pc_target, e.target);
        if (e.chk_lanes)
        begin
            check_field("wdata", ex.wdata, e.wdata);
            check_field("wsel", 32'(ex.wsel), 32'(e.wsel));
        end
    endtask

    task automatic drive_next();
        logic [31:0] r;
        r           = next_rand();
        pc          = {r[31:2], 2'b00};
        valid       = pick(100) >= 8;
        flush       = pick(100) < 5;
        branch_pred = pick(4) == 0;
        instr       = make_instr();
        rs1_data    = next_rand();
        rs2_data    = (pick(8) == 0) ? rs1_data : next_rand();    // Equal operands now and then.
        csr_data    = next_rand();
    endtask

    initial
    begin
        seed          = 32'h150f4102;
        fail_count    = 0;
        run_passed    = 1'b0;
        fail_reported = 1'b0;
        rst_n         = 1'b0;
        valid         = 1'b0;
        instr         = '0;
        pc            = '0;
        rs1_data      = '0;
        rs2_data      = '0;
        branch_pred   = 1'b0;
        csr_data      = '0;
        flush         = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_outputs(predict());           // Controls must be clear out of reset.
        rst_n = 1'b1;
        for (int n = 0; n < N_TXN; n++)
        begin
            drive_next();
            pending = predict();
            @(negedge clk);
            check_outputs(pending);
        end
        if (fail_count == 0)
        begin
            run_passed = 1'b1;
            $display("Test completed successfully");
        end
        else
        begin
            fail_reported = 1'b1;
            $display("Test failed");
        end
        $finish;
    end

    initial
    begin
        #(CLK_PERIOD * (N_TXN + 50));
        $display("Watchdog expired before all transactions were checked");
        abort_run();
    end

    final
    begin
        if (!run_passed && !fail_reported)
        begin
            $display("Test failed");    // The run stopped early, e.g. on a bound assertion.
        end
    end

endmodule

`default_nettype wire

// File: rv_ex_top.sv
`default_nettype none

module rv_ex_top
(
    input  wire                             i_clk,
    input  wire                             i_rst_n,
    input  wire                             i_valid,
    input  wire [rv_pkg::XLEN-1:0]          i_instr,
    input  wire [rv_pkg::IADDR_BITS-1:0]    i_pc,
    input  wire [rv_pkg::XLEN-1:0]          i_rs1_data,
    input  wire [rv_pkg::XLEN-1:0]          i_rs2_data,
    input  wire                             i_branch_pred,
    input  wire [rv_pkg::XLEN-1:0]          i_csr_data,
    input  wire                             i_flush,
    output rv_pkg::ex_out_t                 o_ex
);

    rv_pkg::ex_in_t bundle;                 // Decoded instruction, sampled every edge.

    rv_decode u_decode
    (
        .i_valid       (i_valid),
        .i_instr       (i_instr),
        .i_pc          (i_pc),
        .i_rs1_data    (i_rs1_data),
        .i_rs2_data    (i_rs2_data),
        .i_branch_pred (i_branch_pred),
        .i_csr_data    (i_csr_data),
        .o_bundle      (bundle)
    );

    rv_execute u_execute
    (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_flush       (i_flush),
        .i_bundle      (bundle),
        .o_ex          (o_ex)
    );

endmodule

`default_nettype wire

// File: rv_execute.sv
`default_nettype none

module rv_execute
(
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire                     i_flush,
    input  wire rv_pkg::ex_in_t     i_bundle,
    output rv_pkg::ex_out_t         o_ex
);

    logic                               store_q;
    logic                               reg_write_q;
    logic [rv_pkg::REG_BITS-1:0]        rd_q;
    rv_pkg::res_src_t                   res_src_q;
    logic                               to_trap_q;
    logic                               inst_jal_jalr_q;
    logic                               inst_branch_q;
    logic                               branch_pred_q;

    logic [rv_pkg::XLEN-1:0]            op1_q;
    logic [rv_pkg::XLEN-1:0]            op2_q;
    logic [rv_pkg::XLEN-1:0]            reg_data2_q;
    rv_pkg::alu_res_t                   res_q;
    rv_pkg::alu_ctrl_t                  ctrl_q;
    logic                               csr_read_q;
    logic [rv_pkg::F3_BITS-1:0]         funct3_q;
    logic [rv_pkg::IADDR_BITS-1:0]      pc_next_q;
    logic [rv_pkg::IADDR_BITS-1:0]      target_base_q;
    logic [rv_pkg::IADDR_BITS-1:0]      target_offset_q;

    logic                               op_b_sel;
    logic [rv_pkg::XLEN-1:0]            op_b;
    logic [rv_pkg::XLEN:0]              add;
    logic                               carry;
    logic                               negative;
    logic                               overflow;
    logic                               cmp_raw;
    logic                               cmp_result;
    logic [rv_pkg::XLEN-1:0]            arith_result;
    logic [rv_pkg::XLEN-1:0]            bits_result;
    logic [4:0]                         shamt;
    logic [rv_pkg::XLEN-1:0]            shl;
    logic [rv_pkg::XLEN-1:0]            shr;
    logic [rv_pkg::XLEN-1:0]            shift_result;
    logic                               pc_select;
    logic [rv_pkg::IADDR_BITS-1:0]      pc_target;
    logic [rv_pkg::XLEN-1:0]            result;
    logic [rv_pkg::XLEN-1:0]            wdata;
    logic [rv_pkg::LANES-1:0]           wsel;

    // Control fields. A flush turns the next cycle into a bubble.
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            store_q         <= 1'b0;
            reg_write_q     <= 1'b0;
            rd_q            <= '0;
            res_src_q       <= '0;
            to_trap_q       <= 1'b0;
            inst_jal_jalr_q <= 1'b0;
            inst_branch_q   <= 1'b0;
            branch_pred_q   <= 1'b0;
        end
        else if (i_flush)
        begin
            store_q         <= 1'b0;
            reg_write_q     <= 1'b0;
            rd_q            <= '0;
            res_src_q       <= '0;
            to_trap_q       <= 1'b0;
            inst_jal_jalr_q <= 1'b0;
            inst_branch_q   <= 1'b0;
            branch_pred_q   <= 1'b0;
        end
        else
        begin
            store_q         <= i_bundle.store;
            reg_write_q     <= i_bundle.reg_write;
            rd_q            <= i_bundle.rd;
            res_src_q       <= i_bundle.res_src;
            to_trap_q       <= i_bundle.to_trap;
            inst_jal_jalr_q <= i_bundle.inst_jal_jalr;
            inst_branch_q   <= i_bundle.inst_branch;
            branch_pred_q   <= i_bundle.branch_pred;
        end
    end

    always_ff @(posedge i_clk)
    begin
        op1_q           <= i_bundle.op1;
        op2_q           <= i_bundle.op2;
        reg_data2_q     <= i_bundle.reg_data2;
        res_q           <= i_bundle.res;
        ctrl_q          <= i_bundle.ctrl;
        csr_read_q      <= i_bundle.csr_read;
        funct3_q        <= i_bundle.funct3;
        pc_next_q       <= i_bundle.pc_next;
        target_base_q   <= i_bundle.pc_target_base;
        target_offset_q <= i_bundle.pc_target_offset;
    end

    // One adder serves add, subtract and every compare.
    assign op_b_sel = ctrl_q.arith_sub | res_q.cmp;
    assign op_b     = op_b_sel ? ~op2_q : op2_q;
    assign add      = {1'b0, op1_q} + {1'b0, op_b} + {{rv_pkg::XLEN{1'b0}}, op_b_sel};
    assign carry    = add[rv_pkg::XLEN];
    assign negative = add[rv_pkg::XLEN-1];
    assign overflow = (op1_q[rv_pkg::XLEN-1] ^ op2_q[rv_pkg::XLEN-1])
                    & (op1_q[rv_pkg::XLEN-1] ^ negative);

    assign cmp_raw = (ctrl_q.cmp_eq  & (op1_q == op2_q))
                   | (ctrl_q.cmp_lts & (negative ^ overflow))
                   | (ctrl_q.cmp_ltu & !carry);   // No carry out means a borrow.
    assign cmp_result = cmp_raw ^ ctrl_q.cmp_inversed;

    assign arith_result = {rv_pkg::XLEN{ctrl_q.arith_add | ctrl_q.arith_sub}}
                        & add[rv_pkg::XLEN-1:0];

    assign bits_result = ({rv_pkg::XLEN{ctrl_q.bits_and}} & (op1_q & op2_q))
                       | ({rv_pkg::XLEN{ctrl_q.bits_or}}  & (op1_q | op2_q))
                       | ({rv_pkg::XLEN{ctrl_q.bits_xor}} & (op1_q ^ op2_q));

    assign shamt = op2_q[4:0];
    assign shl   = op1_q << shamt;
    assign shr   = ctrl_q.shift_arithmetical ? unsigned'($signed(op1_q) >>> shamt)
                                             : (op1_q >> shamt);
    assign shift_result = ({rv_pkg::XLEN{ctrl_q.arith_shl}} & shl)
                        | ({rv_pkg::XLEN{ctrl_q.arith_shr}} & shr);

    // A correct prediction needs no redirect; a wrong one goes back to pc_next.
    assign pc_select = (inst_jal_jalr_q | (inst_branch_q & cmp_result)) ^ branch_pred_q;
    assign pc_target = branch_pred_q ? pc_next_q : (target_base_q + target_offset_q);

    always_comb
    begin
        case (1'b1)
        res_src_q.pc_next: result = rv_pkg::XLEN'(pc_next_q);
        csr_read_q:        result = reg_data2_q;
        res_q.cmp:         result = {{(rv_pkg::XLEN-1){1'b0}}, cmp_result};
        res_q.bits:        result = bits_result;
        res_q.shift:       result = shift_result;
        res_q.arith:       result = arith_result;
        default:           result = '0;
        endcase
    end

    always_comb
    begin
        case (funct3_q[1:0])
        2'b00:
        begin
            wdata = {4{reg_data2_q[7:0]}};
            wsel  = 4'b0001 << add[1:0];
        end
        2'b01:
        begin
            wdata = {2{reg_data2_q[15:0]}};
            wsel  = add[1] ? 4'b1100 : 4'b0011;
        end
        default:
        begin
            wdata = reg_data2_q;
            wsel  = 4'b1111;
        end
        endcase
    end

    always_comb
    begin
        o_ex           = '0;
        o_ex.pc_select = pc_select;
        o_ex.result    = result;
        o_ex.add       = add[rv_pkg::XLEN-1:0];
        o_ex.pc_target = pc_target;
        o_ex.store     = store_q;
        o_ex.reg_write = reg_write_q;
        o_ex.rd        = rd_q;
        o_ex.res_src   = res_src_q;
        o_ex.funct3    = funct3_q;
        o_ex.to_trap   = to_trap_q;
        o_ex.wdata     = wdata;
        o_ex.wsel      = wsel;
    end

endmodule

`default_nettype wire

// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int IADDR_BITS = 32;
    localparam int REG_BITS   = 5;
    localparam int F3_BITS    = 3;
    localparam int LANES      = XLEN / 8;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef struct packed {
        logic arith_add;
        logic arith_sub;
        logic arith_shl;
        logic arith_shr;
        logic shift_arithmetical;           // Fill with the sign bit on a right shift.
        logic cmp_eq;
        logic cmp_lts;
        logic cmp_ltu;
        logic cmp_inversed;                 // Inverts the selected compare.
        logic bits_and;
        logic bits_or;
        logic bits_xor;
    } alu_ctrl_t;

    typedef struct packed {
        logic arith;
        logic cmp;
        logic bits;
        logic shift;
    } alu_res_t;

    typedef struct packed {
        logic pc_next;
        logic mem;
        logic alu;
    } res_src_t;

    typedef struct packed {
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic [XLEN-1:0]       reg_data2;   // Store data, or the CSR value on a CSR read.
        alu_res_t              res;
        alu_ctrl_t             ctrl;
        logic                  store;
        logic                  reg_write;
        logic                  inst_jal_jalr;
        logic                  inst_branch;
        logic                  branch_pred;
        logic                  csr_read;
        logic                  to_trap;
        logic [REG_BITS-1:0]   rd;
        logic [F3_BITS-1:0]    funct3;
        res_src_t              res_src;
        logic [IADDR_BITS-1:0] pc_next;
        logic [IADDR_BITS-1:0] pc_target_base;
        logic [IADDR_BITS-1:0] pc_target_offset;
    } ex_in_t;

    typedef struct packed {
        logic                  pc_select;   // Fetch must redirect to pc_target.
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       add;
        logic [IADDR_BITS-1:0] pc_target;
        logic                  store;
        logic                  reg_write;
        logic [REG_BITS-1:0]   rd;
        res_src_t              res_src;
        logic [F3_BITS-1:0]    funct3;
        logic                  to_trap;
        logic [XLEN-1:0]       wdata;
        logic [LANES-1:0]      wsel;
    } ex_out_t;

endpackage

`default_nettype wire
